// File: common/pic_macros.svh
`ifndef PIC_MACROS_SVH
`define PIC_MACROS_SVH

// level count and derived widths
`define PIC_LEVELS 8
`define PIC_IDX_W 3
`define PIC_BUS_W 8
`define PIC_BASE_W 5

// icw1 / icw4 fields
`define ICW1_SEL_BIT 4
`define ICW1_LTIM_BIT 3
`define ICW1_IC4_BIT 0
`define ICW4_AEOI_BIT 1

// ocw3 fields, ocw3 vs ocw2 picked by bit 3
`define OCW3_SEL_BIT 3
`define OCW3_POLL_BIT 2
`define OCW3_RR_BIT 1
`define OCW3_RIS_BIT 0

// ocw2 codes, din[7:5]
`define OCW2_NONSPEC_EOI 3'b001
`define OCW2_SPEC_EOI 3'b011

`define POLL_VALID_BIT 7

`endif

// File: common/pic_pkg.sv
`default_nettype none

`include "pic_macros.svh"

package pic_pkg;

	typedef logic [`PIC_LEVELS-1:0] level_vec_t;
	typedef logic [`PIC_IDX_W-1:0] level_idx_t;
	typedef logic [`PIC_BASE_W-1:0] vector_base_t;
	typedef logic [`PIC_BUS_W-1:0] bus_byte_t;

	// initialization sequence
	typedef enum logic [1:0]
	{
		CMD_READY,
		CMD_WAIT_ICW2,
		CMD_WAIT_ICW4
	} cmd_state_t;

	// acknowledge / poll handling
	typedef enum logic [1:0]
	{
		ACK_IDLE,
		ACK_WAIT_SECOND,
		ACK_POLL_PENDING
	} ack_state_t;

	typedef struct packed
	{
		vector_base_t vec_base;    // icw2[7:3]
		logic         level_trig;  // icw1 ltim
		logic         auto_eoi;
		logic         read_isr;    // ocw3 read select, 0 = irr
		logic         initializing;
	} pic_cfg_t;

	typedef struct packed
	{
		logic req;
		logic isr;
	} cell_state_t;

endpackage

`default_nettype wire

// File: hw/command/pic_command.sv
`default_nettype none

`include "pic_macros.svh"

module pic_command (
	input  logic                clk,
	input  logic                rst_n,
	input  pic_pkg::bus_byte_t  din,
	input  logic                a0,
	input  logic                wr,
	input  pic_pkg::level_vec_t isr_top,
	output pic_pkg::pic_cfg_t   cfg,
	output pic_pkg::level_vec_t mask,
	output pic_pkg::level_vec_t eoi_clear,
	output logic                poll_armed,
	output logic                init_clear
);

	pic_pkg::cmd_state_t state;
	pic_pkg::cmd_state_t state_nxt;
	logic icw4_needed;
	logic cmd_ready;
	logic icw1_wr;
	logic icw2_wr;
	logic icw4_wr;
	logic ocw1_wr;
	logic ocw2_wr;
	logic ocw3_wr;

	// ######################################################################
	// write decode

	assign cmd_ready = (state == pic_pkg::CMD_READY);

	assign icw1_wr = wr & ~a0 & din[`ICW1_SEL_BIT];  // restarts init from any state
	assign icw2_wr = wr & a0 & (state == pic_pkg::CMD_WAIT_ICW2);
	assign icw4_wr = wr & a0 & (state == pic_pkg::CMD_WAIT_ICW4);
	assign ocw1_wr = wr & a0 & cmd_ready;
	assign ocw2_wr = wr & ~a0 & ~din[`ICW1_SEL_BIT] & ~din[`OCW3_SEL_BIT] & cmd_ready;
	assign ocw3_wr = wr & ~a0 & ~din[`ICW1_SEL_BIT] & din[`OCW3_SEL_BIT] & cmd_ready;

	assign poll_armed = ocw3_wr & din[`OCW3_POLL_BIT];
	assign init_clear = icw1_wr;

	always_comb
	begin
		state_nxt = state;
		if (icw1_wr)
			state_nxt = pic_pkg::CMD_WAIT_ICW2;
		else if (icw2_wr)
			state_nxt = icw4_needed ? pic_pkg::CMD_WAIT_ICW4 : pic_pkg::CMD_READY;
		else if (icw4_wr)
			state_nxt = pic_pkg::CMD_READY;
	end

	// ######################################################################
	// config and mask registers

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state       <= pic_pkg::CMD_READY;
			icw4_needed <= 1'b0;
			cfg         <= '0;
			mask        <= '1;
		end
		else
		begin
			state            <= state_nxt;
			cfg.initializing <= (state_nxt != pic_pkg::CMD_READY);
			if (icw1_wr)
			begin
				cfg.level_trig <= din[`ICW1_LTIM_BIT];
				cfg.auto_eoi   <= 1'b0;
				cfg.read_isr   <= 1'b0;
				icw4_needed    <= din[`ICW1_IC4_BIT];
				mask           <= '0;  // icw1 clears imr
			end
			if (icw2_wr)
				cfg.vec_base <= din[`PIC_BUS_W-1 -: `PIC_BASE_W];
			if (icw4_wr)
				cfg.auto_eoi <= din[`ICW4_AEOI_BIT];
			if (ocw1_wr)
				mask <= din;
			if (ocw3_wr && din[`OCW3_RR_BIT])
				cfg.read_isr <= din[`OCW3_RIS_BIT];
		end
	end

	// eoi pulse, same cycle as the ocw2 write
	always_comb
	begin
		eoi_clear = '0;
		if (ocw2_wr)
		begin
			case (din[7:5])
				`OCW2_NONSPEC_EOI: eoi_clear = isr_top;
				`OCW2_SPEC_EOI: eoi_clear = pic_pkg::level_vec_t'(1) << din[`PIC_IDX_W-1:0];
				default: eoi_clear = '0;  // rotate codes ignored
			endcase
		end
	end

	// mask only moves after icw1 or an ocw1 taken in ready
	a_mask_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(mask != $past(mask)) |-> $past(cmd_ready || icw1_wr));

endmodule

`default_nettype wire

// File: hw/irq_level_cell.sv
`default_nettype none

module irq_level_cell (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 irq_line,
	input  logic                 level_trig,
	input  logic                 masked,
	input  logic                 init_clear,
	input  logic                 isr_set,
	input  logic                 isr_clear,
	output pic_pkg::cell_state_t state
);

	logic line_q;
	logic req;
	logic isr;
	logic rise;
	logic req_hit;

	assign rise    = irq_line & ~line_q;
	assign req_hit = level_trig ? irq_line : rise;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			line_q <= 1'b0;
			req    <= 1'b0;
			isr    <= 1'b0;
		end
		else
		begin
			line_q <= irq_line;
			if (init_clear)
			begin
				req <= 1'b0;
				isr <= 1'b0;
			end
			else
			begin
				if (isr_set)
					req <= 1'b0;  // taken by the ack
				else if (req_hit)
					req <= 1'b1;
				else if (level_trig && !irq_line)
					req <= 1'b0;
				if (isr_set)
					isr <= 1'b1;
				else if (isr_clear)
					isr <= 1'b0;
			end
		end
	end

	// mask hides the request, the bit itself stays latched
	assign state.req = req & ~masked;
	assign state.isr = isr;

	a_set_clear: assert property (@(posedge clk) disable iff (!rst_n)
		!(isr_set && isr_clear));

endmodule

`default_nettype wire

// File: hw/priority_resolver.sv
`default_nettype none

`include "pic_macros.svh"

module priority_resolver (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  pic_pkg::cell_state_t [`PIC_LEVELS-1:0] cells,
	input  pic_pkg::level_vec_t                    mask,
	output logic                                   req_valid,
	output pic_pkg::level_idx_t                    req_level,
	output pic_pkg::level_vec_t                    irr,
	output pic_pkg::level_vec_t                    isr,
	output pic_pkg::level_vec_t                    isr_top
);

	pic_pkg::level_vec_t pending;
	pic_pkg::level_idx_t pend_idx;
	pic_pkg::level_idx_t isr_idx;
	logic outranks;

	always_comb
	begin
		for (int i = 0; i < `PIC_LEVELS; i++)
		begin
			irr[i] = cells[i].req;
			isr[i] = cells[i].isr;
		end
	end

	assign pending = irr & ~mask;
	assign isr_top = isr & (~isr + 1'b1);  // lowest set bit, one-hot

	// scan top down so level 0 ends up winning
	always_comb
	begin
		pend_idx = '0;
		isr_idx  = '0;
		for (int i = `PIC_LEVELS - 1; i >= 0; i--)
		begin
			if (pending[i])
				pend_idx = pic_pkg::level_idx_t'(i);
			if (isr[i])
				isr_idx = pic_pkg::level_idx_t'(i);
		end
	end

	assign outranks = (|pending) && (!(|isr) || (pend_idx < isr_idx));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			req_valid <= 1'b0;
			req_level <= '0;
		end
		else
		begin
			req_valid <= outranks;
			req_level <= pend_idx;
		end
	end

endmodule

`default_nettype wire

// File: hw/ack/pic_ack_sequencer.sv
`default_nettype none

`include "pic_macros.svh"

module pic_ack_sequencer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                inta,
	input  logic                rd,
	input  pic_pkg::pic_cfg_t   cfg,
	input  logic                poll_armed,
	input  logic                req_valid,
	input  pic_pkg::level_idx_t req_level,
	input  pic_pkg::level_vec_t irr,
	input  pic_pkg::level_vec_t isr,
	input  pic_pkg::level_vec_t eoi_clear,
	output pic_pkg::level_vec_t isr_set,
	output pic_pkg::level_vec_t isr_clear,
	output logic                intr,
	output pic_pkg::bus_byte_t  dout,
	output logic                dout_valid
);

	pic_pkg::ack_state_t state;
	pic_pkg::ack_state_t state_nxt;
	pic_pkg::level_idx_t ack_level;
	pic_pkg::level_vec_t auto_clear;
	pic_pkg::bus_byte_t poll_byte;
	logic ack_hit;
	logic ack_hold;
	logic ack_start;
	logic poll_rd;
	logic second_ack;

	assign poll_rd    = rd & (state == pic_pkg::ACK_POLL_PENDING);
	assign ack_start  = ~cfg.initializing &
		((inta & (state != pic_pkg::ACK_WAIT_SECOND)) | poll_rd);
	assign second_ack = ~cfg.initializing & inta & (state == pic_pkg::ACK_WAIT_SECOND);

	// ######################################################################
	// sequence

	always_comb
	begin
		state_nxt = state;
		if (cfg.initializing)
			state_nxt = pic_pkg::ACK_IDLE;
		else
		begin
			case (state)
				pic_pkg::ACK_IDLE:
					if (inta)
						state_nxt = pic_pkg::ACK_WAIT_SECOND;
					else if (poll_armed)
						state_nxt = pic_pkg::ACK_POLL_PENDING;
				pic_pkg::ACK_POLL_PENDING:
					if (inta)
						state_nxt = pic_pkg::ACK_WAIT_SECOND;  // inta cancels the poll
					else if (rd)
						state_nxt = pic_pkg::ACK_IDLE;
				pic_pkg::ACK_WAIT_SECOND:
					if (inta)
						state_nxt = pic_pkg::ACK_IDLE;
				default:
					state_nxt = pic_pkg::ACK_IDLE;
			endcase
		end
	end

	assign isr_set    = (ack_start & req_valid) ? pic_pkg::level_vec_t'(1) << req_level : '0;
	assign auto_clear = (second_ack & cfg.auto_eoi & ack_hit) ?
		pic_pkg::level_vec_t'(1) << ack_level : '0;
	assign isr_clear  = eoi_clear | auto_clear;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= pic_pkg::ACK_IDLE;
			ack_hit    <= 1'b0;
			ack_hold   <= 1'b0;
			dout_valid <= 1'b0;
		end
		else
		begin
			state      <= state_nxt;
			ack_hold   <= ack_start;  // req_valid is one cycle stale here
			dout_valid <= second_ack | rd;
			if (ack_start)
				ack_hit <= req_valid;
		end
	end

	// no pending request answers zero
	always_comb
	begin
		poll_byte = '0;
		if (req_valid)
		begin
			poll_byte[`POLL_VALID_BIT]    = 1'b1;
			poll_byte[`PIC_IDX_W-1:0] = req_level;
		end
	end

	// ######################################################################
	// data byte

	always_ff @(posedge clk)
	begin
		if (ack_start)
			ack_level <= req_level;
		if (second_ack)
			dout <= {cfg.vec_base, ack_level};  // 8086 form
		else if (poll_rd)
			dout <= poll_byte;
		else if (rd)
			dout <= cfg.read_isr ? isr : irr;
	end

	assign intr = req_valid & ~ack_hold & ~cfg.initializing &
		(state != pic_pkg::ACK_WAIT_SECOND);

	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		dout_valid |=> !dout_valid);

endmodule

`default_nettype wire

// File: hw/pic_top.sv
`default_nettype none

`include "pic_macros.svh"

module pic_top (
	input  logic                clk,
	input  logic                rst_n,
	input  pic_pkg::bus_byte_t  din,
	input  logic                a0,
	input  logic                wr,
	input  logic                rd,
	input  logic                inta,
	input  pic_pkg::level_vec_t irq,
	output pic_pkg::bus_byte_t  dout,
	output logic                dout_valid,
	output logic                intr
);

	pic_pkg::pic_cfg_t cfg;
	pic_pkg::level_vec_t mask;
	pic_pkg::level_vec_t eoi_clear;
	pic_pkg::level_vec_t isr_set;
	pic_pkg::level_vec_t isr_clear;
	pic_pkg::level_vec_t irr;
	pic_pkg::level_vec_t isr;
	pic_pkg::level_vec_t isr_top;
	pic_pkg::level_idx_t req_level;
	pic_pkg::cell_state_t [`PIC_LEVELS-1:0] cells;
	logic poll_armed;
	logic init_clear;
	logic req_valid;

	pic_command u_command (
		.clk        (clk),
		.rst_n      (rst_n),
		.din        (din),
		.a0         (a0),
		.wr         (wr),
		.isr_top    (isr_top),
		.cfg        (cfg),
		.mask       (mask),
		.eoi_clear  (eoi_clear),
		.poll_armed (poll_armed),
		.init_clear (init_clear)
	);

	// one cell per request line
	genvar i;
	generate
		for (i = 0; i < `PIC_LEVELS; i++)
		begin : g_level
			irq_level_cell u_cell (
				.clk        (clk),
				.rst_n      (rst_n),
				.irq_line   (irq[i]),
				.level_trig (cfg.level_trig),
				.masked     (mask[i]),
				.init_clear (init_clear),
				.isr_set    (isr_set[i]),
				.isr_clear  (isr_clear[i]),
				.state      (cells[i])
			);
		end
	endgenerate

	priority_resolver u_resolver (
		.clk       (clk),
		.rst_n     (rst_n),
		.cells     (cells),
		.mask      (mask),
		.req_valid (req_valid),
		.req_level (req_level),
		.irr       (irr),
		.isr       (isr),
		.isr_top   (isr_top)
	);

	pic_ack_sequencer u_ack (
		.clk        (clk),
		.rst_n      (rst_n),
		.inta       (inta),
		.rd         (rd),
		.cfg        (cfg),
		.poll_armed (poll_armed),
		.req_valid  (req_valid),
		.req_level  (req_level),
		.irr        (irr),
		.isr        (isr),
		.eoi_clear  (eoi_clear),
		.isr_set    (isr_set),
		.isr_clear  (isr_clear),
		.intr       (intr),
		.dout       (dout),
		.dout_valid (dout_valid)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial
		clk = 1'b0;

	always
		#(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: tests/pic_tb.sv
`default_nettype none

`include "pic_macros.svh"

module pic_tb;

	localparam int KIND_VECTOR = 0;
	localparam int KIND_POLL   = 1;
	localparam int KIND_REG    = 2;
	localparam int WAIT_LIMIT  = 200;

	typedef struct packed
	{
		logic               is_reg;
		pic_pkg::bus_byte_t value;
	} expect_t;

	logic clk;
	logic rst_n;
	pic_pkg::bus_byte_t din;
	logic a0;
	logic wr;
	logic rd;
	logic inta;
	pic_pkg::level_vec_t irq;
	pic_pkg::bus_byte_t dout;
	logic dout_valid;
	logic intr;

	// reference model state
	pic_pkg::vector_base_t m_base;
	pic_pkg::level_vec_t m_mask;
	pic_pkg::level_vec_t m_req;   // latched requests before the mask
	pic_pkg::level_vec_t m_isr;
	pic_pkg::level_vec_t m_lines;
	logic m_level_trig;
	logic m_auto_eoi;
	logic m_read_isr;

	expect_t exp_q[$];
	expect_t cur;
	int n_sent;
	int n_done;
	int loops;
	logic [31:0] rng;
	pic_pkg::level_vec_t pattern;
	pic_pkg::level_idx_t lvl;

	tb_clock u_clock (.clk(clk));

	pic_top dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.din        (din),
		.a0         (a0),
		.wr         (wr),
		.rd         (rd),
		.inta       (inta),
		.irq        (irq),
		.dout       (dout),
		.dout_valid (dout_valid),
		.intr       (intr)
	);

	// ######################################################################
	// model functions

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic pic_pkg::level_vec_t one_hot(input pic_pkg::level_idx_t idx);
		pic_pkg::level_vec_t v;
		v = '0;
		v[idx] = 1'b1;
		return v;
	endfunction

	// level 0 is the highest priority
	function automatic pic_pkg::level_idx_t lowest_level(input pic_pkg::level_vec_t v);
		pic_pkg::level_idx_t idx;
		logic found;
		idx = '0;
		found = 1'b0;
		for (int i = 0; i < `PIC_LEVELS; i++)
		begin
			if (v[i] && !found)
			begin
				idx = pic_pkg::level_idx_t'(i);
				found = 1'b1;
			end
		end
		return idx;
	endfunction

	function automatic logic expect_intr();
		pic_pkg::level_vec_t visible;
		visible = m_req & ~m_mask;
		if (visible == '0)
			return 1'b0;
		return (m_isr == '0) || (lowest_level(visible) < lowest_level(m_isr));
	endfunction

	function automatic pic_pkg::bus_byte_t ref_byte(input int kind);
		pic_pkg::level_vec_t visible;
		pic_pkg::bus_byte_t b;
		visible = m_req & ~m_mask;
		b = '0;
		case (kind)
			KIND_VECTOR: b = {m_base, lowest_level(visible)};
			KIND_POLL:
				if (expect_intr())
					b = {1'b1, 4'b0000, lowest_level(visible)};
			default: b = m_read_isr ? m_isr : visible;  // irr as seen behind the mask
		endcase
		return b;
	endfunction

	// ######################################################################
	// checks

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_byte(input string name, input pic_pkg::bus_byte_t got,
		input pic_pkg::bus_byte_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0t: %s got %02h expected %02h",
				$time, name, got, exp));
	endtask

	task automatic check_vec(input string name, input pic_pkg::level_vec_t got,
		input pic_pkg::level_vec_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0t: %s got %08b expected %08b",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// every answer on dout is matched against the oldest expectation
	always @(negedge clk)
	begin
		if (rst_n && dout_valid)
		begin
			if (exp_q.size() == 0)
				stop_with_failure("dout_valid rose with no read or acknowledge outstanding");
			else
			begin
				cur = exp_q.pop_front();
				if (cur.is_reg)
					check_vec("dout", pic_pkg::level_vec_t'(dout),
						pic_pkg::level_vec_t'(cur.value));
				else
					check_byte("dout", dout, cur.value);
				n_done++;
			end
		end
	end

	initial
	begin
		repeat (20000) @(posedge clk);
		stop_with_failure("watchdog expired, the simulation ran too long");
	end

	// ######################################################################
	// bus tasks

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic write_reg(input logic addr, input pic_pkg::bus_byte_t data);
		@(negedge clk);
		a0  = addr;
		din = data;
		wr  = 1'b1;
		@(negedge clk);
		wr  = 1'b0;
		a0  = 1'b0;
		din = '0;
	endtask

	task automatic pulse_inta();
		@(negedge clk);
		inta = 1'b1;
		@(negedge clk);
		inta = 1'b0;
	endtask

	task automatic expect_answer(input int kind);
		expect_t e;
		e.is_reg = (kind == KIND_REG);
		e.value  = ref_byte(kind);
		exp_q.push_back(e);
		n_sent++;
	endtask

	task automatic pulse_rd(input int kind);
		@(negedge clk);
		expect_answer(kind);
		rd = 1'b1;
		@(negedge clk);
		rd = 1'b0;
	endtask

	task automatic wait_answers();
		int cycles;
		cycles = 0;
		while (n_done < n_sent)
		begin
			if (cycles == WAIT_LIMIT)
				stop_with_failure("timeout, dout_valid never answered a read or acknowledge");
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic wait_intr();
		int cycles;
		cycles = 0;
		while (!intr)
		begin
			if (cycles == WAIT_LIMIT)
				stop_with_failure("timeout, intr never rose");
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic hold_no_intr(input int n);
		repeat (n)
		begin
			@(negedge clk);
			check_bit("intr", intr, 1'b0);
		end
	endtask

	// ######################################################################
	// model-tracking commands

	task automatic init_pic(input logic level, input logic aeoi,
		input pic_pkg::vector_base_t base);
		write_reg(1'b0, {3'b000, 1'b1, level, 3'b001});
		write_reg(1'b1, {base, 3'b000});
		write_reg(1'b1, {6'b000000, aeoi, 1'b1});
		m_base       = base;
		m_level_trig = level;
		m_auto_eoi   = aeoi;
		m_read_isr   = 1'b0;
		m_mask       = '0;
		m_isr        = '0;
		m_req        = level ? m_lines : '0;
		idle(2);
	endtask

	task automatic set_mask(input pic_pkg::level_vec_t m);
		write_reg(1'b1, m);
		m_mask = m;
		idle(2);
	endtask

	task automatic set_lines(input pic_pkg::level_vec_t v);
		@(negedge clk);
		irq = v;
		if (m_level_trig)
			m_req = v;
		else
			m_req = m_req | (v & ~m_lines);  // rising lines only
		m_lines = v;
		idle(2);
	endtask

	task automatic accept_level(input pic_pkg::level_idx_t l);
		m_isr[l] = ~m_auto_eoi;
		m_req[l] = m_level_trig & m_lines[l];  // a held line asks again
	endtask

	task automatic acknowledge();
		pic_pkg::level_idx_t l;
		l = lowest_level(m_req & ~m_mask);
		pulse_inta();
		expect_answer(KIND_VECTOR);
		pulse_inta();
		wait_answers();
		accept_level(l);
		idle(2);
	endtask

	task automatic poll_read();
		logic hit;
		pic_pkg::level_idx_t l;
		hit = expect_intr();
		l = lowest_level(m_req & ~m_mask);
		write_reg(1'b0, 8'h0c);
		pulse_rd(KIND_POLL);
		wait_answers();
		if (hit)
			accept_level(l);
		idle(2);
	endtask

	task automatic read_register(input logic sel_isr);
		write_reg(1'b0, {6'b000010, 1'b1, sel_isr});
		m_read_isr = sel_isr;
		pulse_rd(KIND_REG);
		wait_answers();
	endtask

	task automatic eoi_nonspec();
		write_reg(1'b0, 8'h20);
		if (m_isr != '0)
			m_isr[lowest_level(m_isr)] = 1'b0;
		idle(2);
	endtask

	task automatic eoi_specific(input pic_pkg::level_idx_t l);
		write_reg(1'b0, {3'b011, 2'b00, l});
		m_isr[l] = 1'b0;
		idle(2);
	endtask

	// ######################################################################
	// stimulus

	initial
	begin
		rst_n = 1'b0;
		din   = '0;
		a0    = 1'b0;
		wr    = 1'b0;
		rd    = 1'b0;
		inta  = 1'b0;
		irq   = '0;
		m_base       = '0;
		m_mask       = '1;
		m_req        = '0;
		m_isr        = '0;
		m_lines      = '0;
		m_level_trig = 1'b0;
		m_auto_eoi   = 1'b0;
		m_read_isr   = 1'b0;
		n_sent = 0;
		n_done = 0;
		rng    = 32'd56;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		idle(2);

		// single edge request through a full ack
		rng = xorshift32(rng);
		init_pic(1'b0, 1'b0, rng[12:8]);
		set_mask('0);
		rng = xorshift32(rng);
		set_lines(one_hot(rng[2:0]));
		wait_intr();
		acknowledge();
		eoi_nonspec();
		idle(4);
		check_bit("intr", intr, expect_intr());
		set_lines('0);

		// masked request stays quiet until unmasked
		rng = xorshift32(rng);
		init_pic(1'b0, 1'b0, rng[7:3]);
		lvl = rng[18:16];
		set_mask(rng[31:24] | one_hot(lvl));
		set_lines(one_hot(lvl));
		hold_no_intr(40);
		set_mask('0);
		wait_intr();
		acknowledge();
		eoi_nonspec();
		set_lines('0);

		// priority order, nesting, both eoi kinds
		rng = xorshift32(rng);
		init_pic(1'b0, 1'b0, rng[9:5]);
		pattern = (rng[23:16] & 8'h3e) | 8'hc0;
		set_lines(pattern);
		wait_intr();
		acknowledge();
		idle(3);
		check_bit("intr", intr, expect_intr());
		eoi_nonspec();
		wait_intr();
		lvl = lowest_level(m_req & ~m_mask);
		acknowledge();
		set_lines(pattern | 8'h01);  // level 0 nests
		wait_intr();
		acknowledge();
		eoi_specific(lvl);
		read_register(1'b1);
		eoi_nonspec();
		loops = 0;
		while (((m_req & ~m_mask) != '0) && (loops < `PIC_LEVELS))
		begin
			wait_intr();
			acknowledge();
			eoi_nonspec();
			loops++;
		end
		read_register(1'b0);
		set_lines('0);

		// irr / isr register reads
		rng = xorshift32(rng);
		init_pic(1'b0, 1'b0, rng[4:0]);
		rng = xorshift32(rng);
		set_mask(rng[7:0]);
		set_lines(rng[15:8]);
		read_register(1'b0);
		if (expect_intr())
		begin
			wait_intr();
			acknowledge();
		end
		read_register(1'b1);
		read_register(1'b0);
		set_mask('0);
		read_register(1'b0);
		set_lines('0);

		// poll with nothing pending and then with requests
		rng = xorshift32(rng);
		init_pic(1'b0, 1'b0, rng[14:10]);
		poll_read();
		rng = xorshift32(rng);
		set_lines(rng[7:0] | 8'h80);
		poll_read();
		read_register(1'b1);
		eoi_nonspec();
		set_lines('0);

		// level triggered with auto eoi
		rng = xorshift32(rng);
		init_pic(1'b1, 1'b1, rng[4:0]);
		set_lines(one_hot(rng[10:8]));
		wait_intr();
		acknowledge();
		read_register(1'b1);
		wait_intr();
		acknowledge();
		read_register(1'b1);
		set_lines('0);
		hold_no_intr(20);
		read_register(1'b0);

		idle(4);
		if ((exp_q.size() != 0) || (n_done != n_sent))
			stop_with_failure("some reads or acknowledges were never answered");
		else
		begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/pic_pkg.sv
hw/command/pic_command.sv
hw/irq_level_cell.sv
hw/priority_resolver.sv
hw/ack/pic_ack_sequencer.sv
hw/pic_top.sv
tests/tb_clock.sv
tests/pic_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pic_tb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log
FAIL_MSG = Test FAILED
PASS_MSG = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
